// File: rtl/aclken_bridge_pkg.sv
`default_nettype none

package aclken_bridge_pkg;

  // the last flag travels beside these payload bits
  localparam int DATA_W = 32;

  // a divider ratio d gives one enable pulse every d+1 cycles
  localparam int DIV_W = 4;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [DIV_W-1:0]  div_t;

  // bit 0 marks source ready and bit 1 marks sink valid
  typedef enum logic [2:0] {
    NOT_READY    = 3'b000, // nothing held, source enable not yet seen
    EMPTY        = 3'b001,
    R0_NOT_READY = 3'b010, // r0 holds a word, waiting for a source enable
    R0           = 3'b011,
    R1           = 3'b100, // word parked in r1 until the sink enable comes
    FULL         = 3'b110
  } conv_state_e;

endpackage

`default_nettype wire

// File: rtl/aclken_divider.sv
`timescale 1ns/1ps
`default_nettype none

module aclken_divider (
  input  logic                     ACLK,
  input  logic                     areset,
  input  aclken_bridge_pkg::div_t  div_i,
  output logic                     aclken_o
);

  import aclken_bridge_pkg::*;

  div_t cnt_q; // cycles left until the next pulse

  // the ratio is only taken at reload so a period in progress always completes
  always_ff @(posedge ACLK) begin
    if (areset) begin
      cnt_q    <= '0;
      aclken_o <= 1'b0;
    end else begin
      aclken_o <= (cnt_q == '0);
      if (cnt_q == '0) begin
        cnt_q <= div_i;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // with a steady nonzero ratio the counter was reloaded with it at the pulse,
  // so the next cycle must be quiet
  a_single_cycle_pulse : assert property (
    @(posedge ACLK) disable iff (areset)
    (aclken_o && (div_i != '0) && $stable(div_i)) |=> !aclken_o
  ) else $error("enable pulse lasted two cycles with ratio %0d", div_i);

endmodule

`default_nettype wire

// File: rtl/aclken_conv_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module aclken_conv_fsm (
  input  logic ACLK,
  input  logic areset,
  input  logic s_aclken_i,
  input  logic s_valid_i,
  input  logic m_aclken_i,
  input  logic m_ready_i,
  output logic s_ready_o,
  output logic m_valid_o,
  output logic load_r0_o,
  output logic load_r0_from_r1_o,
  output logic load_r1_o
);

  import aclken_bridge_pkg::*;

  conv_state_e state_q;
  conv_state_e state_d;
  logic        s_xfer; // source offers a word on an enable edge
  logic        m_xfer; // sink takes a word on an enable edge

  assign s_xfer = s_aclken_i & s_valid_i;
  assign m_xfer = m_aclken_i & m_ready_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      NOT_READY: begin
        if (s_aclken_i) begin
          state_d = EMPTY; // ready may only rise on a source enable edge
        end
      end
      EMPTY: begin
        if (s_xfer && m_aclken_i) begin
          state_d = R0;
        end else if (s_xfer) begin
          state_d = R1;
        end
      end
      R0: begin
        if (m_xfer && !s_xfer) begin
          state_d = EMPTY;
        end else if (!m_xfer && s_xfer) begin
          state_d = FULL;
        end
      end
      R0_NOT_READY: begin
        if (s_aclken_i && m_xfer) begin
          state_d = EMPTY;
        end else if (m_xfer) begin
          state_d = NOT_READY;
        end else if (s_aclken_i) begin
          state_d = R0;
        end
      end
      R1: begin
        // r1 moves into r0 on the first sink enable
        if (m_aclken_i && s_aclken_i) begin
          state_d = R0;
        end else if (m_aclken_i) begin
          state_d = R0_NOT_READY;
        end
      end
      FULL: begin
        if (m_xfer && s_aclken_i) begin
          state_d = R0;
        end else if (m_xfer) begin
          state_d = R0_NOT_READY;
        end
      end
      default: begin
        state_d = NOT_READY;
      end
    endcase
  end

  always_ff @(posedge ACLK) begin
    if (areset) begin
      state_q <= NOT_READY;
    end else begin
      state_q <= state_d;
    end
  end

  // in R1 the source is held off, a second word would have no place to go
  // while r0 waits for the sink enable
  assign s_ready_o = (state_q == EMPTY) || (state_q == R0);
  assign m_valid_o = (state_q == R0_NOT_READY) || (state_q == R0) || (state_q == FULL);

  // r0 only follows these on sink enable edges, the converter gates that
  assign load_r0_o = (state_q == EMPTY) ||
                     (state_q == R1) ||
                     ((state_q == R0) && m_ready_i) ||
                     ((state_q == FULL) && m_ready_i);

  assign load_r0_from_r1_o = (state_q == R1) || (state_q == FULL);

  // r1 is a don't care in these states so it can sample the source freely
  assign load_r1_o = (state_q == EMPTY) || (state_q == R0);

endmodule

`default_nettype wire

// File: rtl/aclken_converter.sv
`timescale 1ns/1ps
`default_nettype none

module aclken_converter (
  input  logic                     ACLK,
  input  logic                     areset,
  input  logic                     s_aclken_i,
  input  aclken_bridge_pkg::data_t s_data_i,
  input  logic                     s_last_i,
  input  logic                     s_valid_i,
  output logic                     s_ready_o,
  input  logic                     m_aclken_i,
  output aclken_bridge_pkg::data_t m_data_o,
  output logic                     m_last_o,
  output logic                     m_valid_o,
  input  logic                     m_ready_i
);

  import aclken_bridge_pkg::*;

  data_t r0_data_q;
  logic  r0_last_q;
  data_t r1_data_q;
  logic  r1_last_q;
  logic  load_r0;
  logic  load_r0_from_r1;
  logic  load_r1;

  aclken_conv_fsm u_fsm (
    .ACLK              (ACLK),
    .areset            (areset),
    .s_aclken_i        (s_aclken_i),
    .s_valid_i         (s_valid_i),
    .m_aclken_i        (m_aclken_i),
    .m_ready_i         (m_ready_i),
    .s_ready_o         (s_ready_o),
    .m_valid_o         (m_valid_o),
    .load_r0_o         (load_r0),
    .load_r0_from_r1_o (load_r0_from_r1),
    .load_r1_o         (load_r1)
  );

  // r0 faces the sink and only changes on its enable
  always_ff @(posedge ACLK) begin
    if (m_aclken_i && load_r0) begin
      if (load_r0_from_r1) begin
        r0_data_q <= r1_data_q;
        r0_last_q <= r1_last_q;
      end else begin
        r0_data_q <= s_data_i;
        r0_last_q <= s_last_i;
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (load_r1) begin
      r1_data_q <= s_data_i;
      r1_last_q <= s_last_i;
    end
  end

  assign m_data_o = r0_data_q;
  assign m_last_o = r0_last_q;

  a_m_payload_stable : assert property (
    @(posedge ACLK) disable iff (areset)
    (m_valid_o && !(m_aclken_i && m_ready_i)) |=> ($stable(m_data_o) && $stable(m_last_o))
  ) else $error("sink payload changed while held");

  a_m_valid_held : assert property (
    @(posedge ACLK) disable iff (areset)
    (m_valid_o && !(m_aclken_i && m_ready_i)) |=> m_valid_o
  ) else $error("m_valid_o dropped without a sink transfer");

  // the machine has to restart from NOT_READY and wait for a source enable
  a_ready_low_after_reset : assert property (
    @(posedge ACLK)
    areset |=> !s_ready_o
  ) else $error("s_ready_o high in the cycle after reset");

endmodule

`default_nettype wire

// File: rtl/aclken_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module aclken_bridge_top (
  input  logic                     ACLK,
  input  logic                     areset,
  input  aclken_bridge_pkg::div_t  s_div_i,
  input  aclken_bridge_pkg::div_t  m_div_i,
  output logic                     s_aclken_o,
  input  aclken_bridge_pkg::data_t s_data_i,
  input  logic                     s_last_i,
  input  logic                     s_valid_i,
  output logic                     s_ready_o,
  output logic                     m_aclken_o,
  output aclken_bridge_pkg::data_t m_data_o,
  output logic                     m_last_o,
  output logic                     m_valid_o,
  input  logic                     m_ready_i
);

  // source side enable, also handed out so the source can pace itself
  aclken_divider u_s_div (
    .ACLK     (ACLK),
    .areset   (areset),
    .div_i    (s_div_i),
    .aclken_o (s_aclken_o)
  );

  aclken_divider u_m_div (
    .ACLK     (ACLK),
    .areset   (areset),
    .div_i    (m_div_i),
    .aclken_o (m_aclken_o)
  );

  aclken_converter u_conv (
    .ACLK       (ACLK),
    .areset     (areset),
    .s_aclken_i (s_aclken_o),
    .s_data_i   (s_data_i),
    .s_last_i   (s_last_i),
    .s_valid_i  (s_valid_i),
    .s_ready_o  (s_ready_o),
    .m_aclken_i (m_aclken_o),
    .m_data_o   (m_data_o),
    .m_last_o   (m_last_o),
    .m_valid_o  (m_valid_o),
    .m_ready_i  (m_ready_i)
  );

endmodule

`default_nettype wire

// File: dv/aclken_bridge_checker.sv
`timescale 1ns/1ps
`default_nettype none

module aclken_bridge_checker (
  input  logic                     ACLK,
  input  logic                     areset,
  input  aclken_bridge_pkg::div_t  s_div_i,
  input  aclken_bridge_pkg::div_t  m_div_i,
  input  logic                     s_aclken_i,
  input  aclken_bridge_pkg::data_t s_data_i,
  input  logic                     s_last_i,
  input  logic                     s_valid_i,
  input  logic                     s_ready_i,
  input  logic                     m_aclken_i,
  input  aclken_bridge_pkg::data_t m_data_i,
  input  logic                     m_last_i,
  input  logic                     m_valid_i,
  input  logic                     m_ready_i,
  output int                       pending_o,
  output int                       errors_o
);

  import aclken_bridge_pkg::*;

  logic [DATA_W:0] model_q[$]; // last flag sits above the data word
  logic [DATA_W:0] exp_word;
  string           test_name = "none";
  int              test_errors = 0;
  int              tests_run = 0;
  int              tests_failed = 0;
  logic            held_q = 1'b0;
  logic [DATA_W:0] held_word;
  logic            rst_prev = 1'b0;
  int              gap[2];
  logic            gap_valid[2];
  int              exp_gap[2];
  div_t            div_prev[2];

  initial begin
    errors_o  = 0;
    pending_o = 0;
  end

  task automatic report_value(input string what, input logic [DATA_W:0] exp_v,
                              input logic [DATA_W:0] act_v);
    $display("** Error [%s] %s: expected %0h actual %0h", test_name, what, exp_v, act_v);
    test_errors++;
    errors_o++;
  endtask

  task automatic report_fault(input string what);
    $display("Failure in test %s at %0t: %s", test_name, $time, what);
    test_errors++;
    errors_o++;
  endtask

  // a pulse raised with ratio d is followed by the next one d+1 cycles later
  task automatic track_enable(input int side, input logic en, input div_t div, input string name);
    if (en) begin
      if (gap_valid[side] && (gap[side] != exp_gap[side])) begin
        report_value({name, " period"}, exp_gap[side], gap[side]);
      end
      gap_valid[side] = 1'b1;
      gap[side]       = 1;
      exp_gap[side]   = div_prev[side] + 1;
    end else begin
      gap[side]++;
    end
    div_prev[side] = div;
  endtask

  always @(posedge ACLK) begin
    if (rst_prev && (s_ready_i || m_valid_i)) begin
      report_fault("s_ready_o or m_valid_o high in the cycle after reset");
    end
    if (areset) begin
      model_q.delete(); // words in flight are lost with the reset
      held_q       = 1'b0;
      gap_valid[0] = 1'b0;
      gap_valid[1] = 1'b0;
      div_prev[0]  = s_div_i;
      div_prev[1]  = m_div_i;
    end else begin
      if (held_q && !m_valid_i) begin
        report_fault("m_valid_o dropped without a sink transfer");
      end else if (held_q && (held_word !== {m_last_i, m_data_i})) begin
        report_value("held sink word", held_word, {m_last_i, m_data_i});
      end
      if (m_aclken_i && m_valid_i && m_ready_i) begin
        if (model_q.size() == 0) begin
          report_fault("sink transfer while no word was expected");
        end else begin
          exp_word = model_q.pop_front();
          if (exp_word[DATA_W-1:0] !== m_data_i) begin
            report_value("data", exp_word[DATA_W-1:0], m_data_i);
          end
          if (exp_word[DATA_W] !== m_last_i) begin
            report_value("last", exp_word[DATA_W], m_last_i);
          end
        end
      end
      if (s_aclken_i && s_valid_i && s_ready_i) begin
        model_q.push_back({s_last_i, s_data_i});
      end
      held_q    = m_valid_i && !(m_aclken_i && m_ready_i);
      held_word = {m_last_i, m_data_i};
      track_enable(0, s_aclken_i, s_div_i, "s_aclken_o");
      track_enable(1, m_aclken_i, m_div_i, "m_aclken_o");
    end
    rst_prev  = areset;
    pending_o = model_q.size();
  end

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    if (model_q.size() != 0) begin
      report_fault($sformatf("%0d words never reached the sink", model_q.size()));
    end
    model_q.delete();
    pending_o = 0;
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: PASS", test_name);
    end else begin
      tests_failed++;
      $display("test %s: FAIL with %0d errors", test_name, test_errors);
    end
  endtask

  task automatic print_counts();
    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors_o);
  endtask

endmodule

`default_nettype wire

// File: dv/aclken_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module aclken_bridge_tb;

  import aclken_bridge_pkg::*;

  localparam int WORD_TIMEOUT  = 2000; // cycles one word may wait at the source
  localparam int DRAIN_TIMEOUT = 4000;

  logic  ACLK;
  logic  areset;
  div_t  s_div;
  div_t  m_div;
  logic  s_aclken;
  data_t s_data;
  logic  s_last;
  logic  s_valid;
  logic  s_ready;
  logic  m_aclken;
  data_t m_data;
  logic  m_last;
  logic  m_valid;
  logic  m_ready;
  int    pending;
  int    errors;
  bit    timed_out;

  initial ACLK = 1'b0;
  always #20 ACLK = ~ACLK;

  aclken_bridge_top UUT (
    .ACLK       (ACLK),
    .areset     (areset),
    .s_div_i    (s_div),
    .m_div_i    (m_div),
    .s_aclken_o (s_aclken),
    .s_data_i   (s_data),
    .s_last_i   (s_last),
    .s_valid_i  (s_valid),
    .s_ready_o  (s_ready),
    .m_aclken_o (m_aclken),
    .m_data_o   (m_data),
    .m_last_o   (m_last),
    .m_valid_o  (m_valid),
    .m_ready_i  (m_ready)
  );

  aclken_bridge_checker u_checker (
    .ACLK       (ACLK),
    .areset     (areset),
    .s_div_i    (s_div),
    .m_div_i    (m_div),
    .s_aclken_i (s_aclken),
    .s_data_i   (s_data),
    .s_last_i   (s_last),
    .s_valid_i  (s_valid),
    .s_ready_i  (s_ready),
    .m_aclken_i (m_aclken),
    .m_data_i   (m_data),
    .m_last_i   (m_last),
    .m_valid_i  (m_valid),
    .m_ready_i  (m_ready),
    .pending_o  (pending),
    .errors_o   (errors)
  );

  task automatic apply_reset(input int cycles);
    areset  = 1'b1;
    s_valid = 1'b0;
    m_ready = 1'b0;
    repeat (cycles) begin
      @(posedge ACLK);
    end
    #2;
    areset = 1'b0;
  endtask

  // max_cycles of 0 lets the stream run to its end
  task automatic run_stream(input int n_words, input int pct, input bit rand_last,
                            input int max_cycles);
    int sent;
    int waited;
    int cycles;
    bit took;
    bit en_prev;
    sent    = 0;
    waited  = 0;
    cycles  = 0;
    took    = 1'b0;
    en_prev = s_aclken;
    while ((sent < n_words) && !timed_out && ((max_cycles == 0) || (cycles < max_cycles))) begin
      @(posedge ACLK);
      #2;
      cycles++;
      waited++;
      m_ready = ($urandom_range(99) < pct);
      if (took) begin
        sent++;
        waited = 0;
      end
      // the source lives on its enable, so it only moves right after an enable edge
      if (en_prev && (took || !s_valid)) begin
        s_valid = (sent < n_words);
        s_data  = $urandom;
        if (rand_last) begin
          s_last = ($urandom_range(1) != 0);
        end else begin
          s_last = (sent == n_words - 1);
        end
      end
      if (waited > WORD_TIMEOUT) begin
        timed_out = 1'b1;
        u_checker.report_fault($sformatf("timeout, source word %0d not accepted in %0d cycles",
                                         sent, WORD_TIMEOUT));
      end
      took    = s_aclken && s_valid && s_ready; // outputs are registered, stable until the edge
      en_prev = s_aclken;
    end
  endtask

  task automatic drain_sink(input int pct);
    int waited;
    waited = 0;
    while (!timed_out && ((pending != 0) || m_valid)) begin
      @(posedge ACLK);
      #2;
      waited++;
      m_ready = ($urandom_range(99) < pct);
      if (waited > DRAIN_TIMEOUT) begin
        timed_out = 1'b1;
        u_checker.report_fault("timeout, words still inside the bridge after the drain limit");
      end
    end
    m_ready = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h749a964b));
    timed_out = 1'b0;
    s_div     = '0;
    m_div     = '0;
    s_data    = '0;
    s_last    = 1'b0;
    s_valid   = 1'b0;
    m_ready   = 1'b0;
    apply_reset(16);

    u_checker.begin_test("full_rate");
    run_stream(200, 70, 1'b0, 0);
    drain_sink(70);
    u_checker.end_test();

    u_checker.begin_test("slow_source");
    s_div = 4'd3;
    m_div = 4'd0;
    run_stream(100, 80, 1'b0, 0);
    drain_sink(80);
    u_checker.end_test();

    u_checker.begin_test("slow_sink_backpressure");
    s_div = 4'd0;
    m_div = 4'd5;
    run_stream(150, 25, 1'b0, 0);
    drain_sink(25);
    u_checker.end_test();

    u_checker.begin_test("ratio_change");
    s_div = 4'd2;
    m_div = 4'd6;
    run_stream(40, 60, 1'b1, 0);
    s_div = 4'd5; // picked up by each divider at its next wrap
    m_div = 4'd1;
    run_stream(40, 60, 1'b1, 0);
    drain_sink(60);
    u_checker.end_test();

    u_checker.begin_test("mid_stream_reset");
    s_div = 4'd1;
    m_div = 4'd2;
    run_stream(100, 50, 1'b0, 60);
    apply_reset(4);
    run_stream(50, 50, 1'b0, 0);
    drain_sink(50);
    u_checker.end_test();

    u_checker.print_counts();
    if ((errors == 0) && !timed_out) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
rtl/aclken_bridge_pkg.sv
rtl/aclken_divider.sv
rtl/aclken_conv_fsm.sv
rtl/aclken_converter.sv
rtl/aclken_bridge_top.sv
dv/aclken_bridge_checker.sv
dv/aclken_bridge_tb.sv

// File: Bender.yml
package:
  name: aclken_bridge

sources:
  - rtl/aclken_bridge_pkg.sv
  - rtl/aclken_divider.sv
  - rtl/aclken_conv_fsm.sv
  - rtl/aclken_converter.sv
  - rtl/aclken_bridge_top.sv
  - target: test
    files:
      - dv/aclken_bridge_checker.sv
      - dv/aclken_bridge_tb.sv
